/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = tb_rv_core
FILELIST = tb.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/rv_core_assert.sv */
// bound assertions on reset, fetch address hold, jump redirect and the expected retire table
module rv_core_assert (
    input logic                  ctrl_clk,
    input logic                  ctrl_reset,
    input rv_isa_pkg::word_t     imem_addr,
    input logic                  imem_req,
    input logic                  imem_rdy,
    input logic                  jump,
    input pipe_pkg::wb_payload_t retire,
    input logic                  retire_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [4:0]        n_retire = 5'd20;
    localparam logic [2:0]        n_jumps  = 3'd6;
    localparam rv_isa_pkg::word_t first_pc = 32'h100;

    pipe_pkg::wb_payload_t expected [n_retire]; // rd, data, wb
    rv_isa_pkg::word_t     targets [n_jumps];   // taken jumps in program order
    logic [4:0]            idx;
    logic [2:0]            jump_idx;
    logic                  retired;
    logic                  redirect;
    logic                  table_done;
    rv_isa_pkg::word_t     prev_addr;
    rv_isa_pkg::word_t     want_target;
    int unsigned           fail_count = 0;

    initial begin
        expected[0]  = {5'd1,  32'h0000_0005, 1'b1}; // addi
        expected[1]  = {5'd2,  32'hffff_fffd, 1'b1};
        expected[2]  = {5'd3,  32'h0000_0002, 1'b1}; // add with forwarded x2
        expected[3]  = {5'd4,  32'h0000_0008, 1'b1}; // sub
        expected[4]  = {5'd5,  32'h0000_000d, 1'b1}; // xor
        expected[5]  = {5'd6,  32'hffff_fffd, 1'b1}; // or
        expected[6]  = {5'd7,  32'h0000_0008, 1'b1}; // and
        expected[7]  = {5'd8,  32'h0000_0001, 1'b1}; // slt
        expected[8]  = {5'd9,  32'h0000_0000, 1'b1}; // sltu
        expected[9]  = {5'd10, 32'h0000_0014, 1'b1}; // sll
        expected[10] = {5'd11, 32'h3fff_ffff, 1'b1}; // srl
        expected[11] = {5'd12, 32'hffff_ffff, 1'b1}; // sra
        expected[12] = {5'd13, 32'h1234_5000, 1'b1}; // lui
        expected[13] = {5'd14, 32'h0000_1134, 1'b1}; // auipc at 0x134
        expected[14] = {5'd16, 32'h0000_015c, 1'b1}; // jal link
        expected[15] = {5'd17, 32'h0000_0178, 1'b1};
        expected[16] = {5'd18, 32'h0000_016c, 1'b1}; // jalr link
        expected[17] = {5'd0,  32'h0000_000c, 1'b1}; // write to x0
        expected[18] = {5'd19, 32'h0000_0002, 1'b1}; // x0 + x3
        expected[19] = {5'd20, 32'h0000_02c8, 1'b1};
        targets[0]   = 32'h0000_0144; // bne at 0x13c
        targets[1]   = 32'h0000_014c; // blt at 0x144
        targets[2]   = 32'h0000_0158; // bltu at 0x150
        targets[3]   = 32'h0000_0164; // jal at 0x158
        targets[4]   = 32'h0000_017c; // jalr through x17
        targets[5]   = 32'h0000_018c; // bge at 0x184
    end

    assign retired    = retire_valid && retire.wb; // branches retire without write-back
    assign table_done = (idx == n_retire);
    assign redirect   = jump && imem_req && imem_rdy;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            idx <= '0;
        end else if (retired && !table_done) begin
            idx <= idx + 5'd1;
        end
    end

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            jump_idx <= '0;
        end else if (redirect) begin
            jump_idx <= jump_idx + 3'd1;
        end
    end

    always_ff @(posedge ctrl_clk) begin
        prev_addr <= imem_addr;
        if (redirect && jump_idx < n_jumps) begin
            want_target <= targets[jump_idx];
        end
    end

    a_reset_quiet: assert property (@(posedge ctrl_clk)
        ctrl_reset |=> !retire_valid && !imem_req)
        else begin
            fail_count++;
            $error("retire_valid or imem_req was high during or right after reset");
        end

    a_reset_pc: assert property (@(posedge ctrl_clk) ctrl_reset |=> imem_addr == first_pc)
        else begin
            fail_count++;
            $error("error imem_addr %h expected %h", $sampled(imem_addr), first_pc);
        end

    a_addr_hold: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        !(imem_req && imem_rdy) |=> imem_addr == prev_addr)
        else begin
            fail_count++;
            $error("error imem_addr %h expected %h", $sampled(imem_addr), $sampled(prev_addr));
        end

    a_jump_extra: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        redirect |-> jump_idx < n_jumps)
        else begin
            fail_count++;
            $error("a jump was taken after the last expected taken jump");
        end

    a_redirect: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        redirect |=> imem_addr == want_target)
        else begin
            fail_count++;
            $error("error imem_addr %h expected %h", $sampled(imem_addr), $sampled(want_target));
        end

    a_retire_extra: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        retired |-> !table_done)
        else begin
            fail_count++;
            $error("an instruction retired after the expected sequence had ended");
        end

    a_retire_rd: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        retired && !table_done |-> retire.rd == expected[idx].rd)
        else begin
            fail_count++;
            $error("error retire.rd %h expected %h", $sampled(retire.rd),
                   $sampled(expected[idx].rd));
        end

    a_retire_data: assert property (@(posedge ctrl_clk) disable iff (ctrl_reset)
        retired && !table_done |-> retire.data == expected[idx].data)
        else begin
            fail_count++;
            $error("error retire.data %h expected %h", $sampled(retire.data),
                   $sampled(expected[idx].data));
        end

endmodule

bind rv_core rv_core_assert assert_i (
    .ctrl_clk     (ctrl_clk),
    .ctrl_reset   (ctrl_reset),
    .imem_addr    (imem_addr),
    .imem_req     (imem_req),
    .imem_rdy     (imem_rdy),
    .jump         (jump),
    .retire       (retire),
    .retire_valid (retire_valid)
);

/* bench/tb_rv_core.sv */
// rv_core testbench with clock, reset, instruction memory model, random ready and timeout
module tb_rv_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam rv_isa_pkg::word_t start_pc   = 32'h100;
    localparam int                prog_len   = 36;
    localparam int                max_cycles = prog_len * 4 + 256; // 400
    localparam logic [6:0]        op_imm     = rv_isa_pkg::opc_op_imm;
    localparam logic [6:0]        op_jalr    = rv_isa_pkg::opc_jalr;
    localparam logic [6:0]        op_lui     = rv_isa_pkg::opc_lui;
    localparam logic [6:0]        op_auipc   = rv_isa_pkg::opc_auipc;

    logic                  ctrl_clk = 1'b0;
    logic                  ctrl_reset;
    rv_isa_pkg::word_t     imem_addr;
    logic                  imem_req;
    rv_isa_pkg::word_t     imem_data;
    logic                  imem_rdy;
    pipe_pkg::wb_payload_t retire;
    logic                  retire_valid;

    rv_isa_pkg::word_t prog [prog_len];
    rv_isa_pkg::word_t marker; // must never retire
    integer            seed = 32'h93ed284b;
    int                cycles = 0;

    function automatic rv_isa_pkg::word_t reg_form(input logic [6:0] f7, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv_isa_pkg::word_t imm_form(input logic [11:0] imm, input logic [4:0] rs1,
                                                   input logic [2:0] f3, input logic [4:0] rd,
                                                   input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_isa_pkg::word_t upper_form(input logic [19:0] imm, input logic [4:0] rd,
                                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_isa_pkg::word_t branch_form(input logic [12:0] off,
                                                      input logic [4:0] rs2,
                                                      input logic [4:0] rs1,
                                                      input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv_isa_pkg::word_t jal_form(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // outside the program the memory answers with nops
    function automatic rv_isa_pkg::word_t fetch_word(input rv_isa_pkg::word_t addr);
        rv_isa_pkg::word_t slot;
        slot = (addr - start_pc) >> 2;
        if (addr < start_pc || slot >= prog_len) begin
            return 32'h0000_0013;
        end
        return prog[slot[5:0]];
    endfunction

    always #2 ctrl_clk = ~ctrl_clk;

    rv_core #(
        .reset_pc (start_pc)
    ) dut_i (
        .ctrl_clk     (ctrl_clk),
        .ctrl_reset   (ctrl_reset),
        .imem_addr    (imem_addr),
        .imem_req     (imem_req),
        .imem_data    (imem_data),
        .imem_rdy     (imem_rdy),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

    always @(posedge ctrl_clk) begin
        #1;
        imem_rdy  = ($random(seed) & 3) != 0; // ready about 3 cycles in 4
        imem_data = fetch_word(imem_addr);
    end

    always @(posedge ctrl_clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout after %0d cycles, the retire sequence did not complete", cycles);
            $display("summary: %0d assertion failures", dut_i.assert_i.fail_count);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        ctrl_reset = 1'b1;
        imem_rdy   = 1'b0;
        imem_data  = 32'h0000_0013;
        marker     = imm_form(12'h7ff, 5'd0, 3'b000, 5'd15, op_imm);
        prog[0]  = imm_form(12'd5, 5'd0, 3'b000, 5'd1, op_imm);   // addi x1, x0, 5
        prog[1]  = imm_form(12'hffd, 5'd0, 3'b000, 5'd2, op_imm); // addi x2, x0, -3
        prog[2]  = reg_form(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);     // add x3, x1, x2
        prog[3]  = reg_form(7'h20, 5'd2, 5'd1, 3'b000, 5'd4);     // sub x4, x1, x2
        prog[4]  = reg_form(7'h00, 5'd1, 5'd4, 3'b100, 5'd5);     // xor x5, x4, x1
        prog[5]  = reg_form(7'h00, 5'd2, 5'd5, 3'b110, 5'd6);     // or x6, x5, x2
        prog[6]  = reg_form(7'h00, 5'd4, 5'd6, 3'b111, 5'd7);     // and x7, x6, x4
        prog[7]  = reg_form(7'h00, 5'd1, 5'd2, 3'b010, 5'd8);     // slt x8, x2, x1
        prog[8]  = reg_form(7'h00, 5'd1, 5'd2, 3'b011, 5'd9);     // sltu x9, x2, x1
        prog[9]  = reg_form(7'h00, 5'd3, 5'd1, 3'b001, 5'd10);    // sll x10, x1, x3
        prog[10] = reg_form(7'h00, 5'd3, 5'd2, 3'b101, 5'd11);    // srl x11, x2, x3
        prog[11] = reg_form(7'h20, 5'd3, 5'd2, 3'b101, 5'd12);    // sra x12, x2, x3
        prog[12] = upper_form(20'h12345, 5'd13, op_lui);
        prog[13] = upper_form(20'h00001, 5'd14, op_auipc);
        prog[14] = branch_form(13'd8, 5'd2, 5'd1, 3'b000);        // beq not taken
        prog[15] = branch_form(13'd8, 5'd2, 5'd1, 3'b001);        // bne taken
        prog[16] = marker;
        prog[17] = branch_form(13'd8, 5'd1, 5'd2, 3'b100);        // blt x2, x1 taken
        prog[18] = marker;
        prog[19] = branch_form(13'd8, 5'd2, 5'd1, 3'b111);        // bgeu not taken
        prog[20] = branch_form(13'd8, 5'd2, 5'd1, 3'b110);        // bltu taken
        prog[21] = marker;
        prog[22] = jal_form(21'd12, 5'd16);                       // jal x16, +12
        prog[23] = marker;
        prog[24] = marker;
        prog[25] = imm_form(12'h178, 5'd0, 3'b000, 5'd17, op_imm);
        prog[26] = imm_form(12'd4, 5'd17, 3'b000, 5'd18, op_jalr); // jalr x18, 4(x17)
        prog[27] = marker;
        prog[28] = marker;
        prog[29] = marker;
        prog[30] = marker;
        prog[31] = imm_form(12'd7, 5'd1, 3'b000, 5'd0, op_imm);   // addi x0, x1, 7
        prog[32] = reg_form(7'h00, 5'd3, 5'd0, 3'b000, 5'd19);    // add x19, x0, x3
        prog[33] = branch_form(13'd8, 5'd2, 5'd1, 3'b101);        // bge taken
        prog[34] = marker;
        prog[35] = reg_form(7'h00, 5'd18, 5'd16, 3'b000, 5'd20);  // add x20, x16, x18
        repeat (5) @(posedge ctrl_clk);
        #1;
        ctrl_reset = 1'b0;
        while (!dut_i.assert_i.table_done) begin
            @(posedge ctrl_clk);
        end
        repeat (16) @(posedge ctrl_clk); // room for stray retires
        $display("summary: %0d assertion failures", dut_i.assert_i.fail_count);
        if (dut_i.assert_i.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* common/pipe_pkg.sv */
// stage payload structs, forwarding struct and alu operation codes
package pipe_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // fetch -> decode
    typedef struct packed {
        rv_isa_pkg::inst_t inst;
        rv_isa_pkg::word_t pc;
    } fetch_payload_t;

    // decode -> execute
    typedef struct packed {
        rv_isa_pkg::word_t     op1;
        rv_isa_pkg::word_t     op2;
        rv_isa_pkg::reg_addr_t rd;
        alu_op_t               alu_op;
        logic                  wb;
    } exec_payload_t;

    // execute -> register file, also the retire trace
    typedef struct packed {
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     data;
        logic                  wb;
    } wb_payload_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::word_t     data;
    } fwd_t;

endpackage

/* common/rv_isa_pkg.sv */
// rv32i opcodes, funct3 codes, field widths, word and instruction types
package rv_isa_pkg;

    localparam int xlen       = 32;
    localparam int opcode_w   = 7;
    localparam int reg_addr_w = 5;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [funct3_w-1:0]   funct3_t;

    typedef enum logic [opcode_w-1:0] {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_t;

    // alu funct3
    localparam funct3_t f3_add_sub = 3'b000; // sub only on OP with funct7 bit 5
    localparam funct3_t f3_sll     = 3'b001;
    localparam funct3_t f3_slt     = 3'b010;
    localparam funct3_t f3_sltu    = 3'b011;
    localparam funct3_t f3_xor     = 3'b100;
    localparam funct3_t f3_srx     = 3'b101; // srl or sra
    localparam funct3_t f3_or      = 3'b110;
    localparam funct3_t f3_and     = 3'b111;

    // branch funct3, bit 0 inverts the test
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    typedef struct packed {
        logic [funct7_w-1:0] funct7;
        reg_addr_t           rs2;
        reg_addr_t           rs1;
        funct3_t             funct3;
        reg_addr_t           rd;
        opcode_t             opcode;
    } inst_t;

    localparam word_t inst_bytes = 32'd4;

endpackage

/* decode/branch_unit.sv */
// branch condition and jump target for jal, jalr and conditional branches
module branch_unit (
    input  rv_isa_pkg::inst_t inst,
    input  rv_isa_pkg::word_t pc,
    input  rv_isa_pkg::word_t op1,
    input  rv_isa_pkg::word_t op2,
    input  logic              live,
    output logic              jump,
    output rv_isa_pkg::word_t jump_target
);

    rv_isa_pkg::word_t raw;
    rv_isa_pkg::word_t off_b;
    rv_isa_pkg::word_t off_j;
    rv_isa_pkg::word_t off_i;
    logic              taken;

    assign raw   = inst;
    assign off_b = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
    assign off_j = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
    assign off_i = {{20{raw[31]}}, raw[31:20]};

    always_comb begin
        case (inst.funct3)
            rv_isa_pkg::f3_beq, rv_isa_pkg::f3_bne:
                taken = (op1 == op2) ^ inst.funct3[0];
            rv_isa_pkg::f3_blt, rv_isa_pkg::f3_bge:
                taken = ($signed(op1) < $signed(op2)) ^ inst.funct3[0];
            rv_isa_pkg::f3_bltu, rv_isa_pkg::f3_bgeu:
                taken = (op1 < op2) ^ inst.funct3[0];
            default: taken = 1'b0;
        endcase
    end

    assign jump = live && (inst.opcode == rv_isa_pkg::opc_jal ||
                           inst.opcode == rv_isa_pkg::opc_jalr ||
                           (inst.opcode == rv_isa_pkg::opc_branch && taken));

    always_comb begin
        case (inst.opcode)
            rv_isa_pkg::opc_jal:  jump_target = pc + off_j;
            rv_isa_pkg::opc_jalr: jump_target = (op1 + off_i) & ~rv_isa_pkg::word_t'(1);
            default:              jump_target = pc + off_b;
        endcase
    end

endmodule

/* decode/decode_stage.sv */
// instruction decode, immediates, operand forwarding and jump squash
module decode_stage (
    input  logic                     ctrl_clk,
    input  logic                     ctrl_reset,
    input  logic                     hold,
    input  pipe_pkg::fetch_payload_t in,
    input  logic                     in_valid,
    output rv_isa_pkg::reg_addr_t    rs1,
    output rv_isa_pkg::reg_addr_t    rs2,
    input  rv_isa_pkg::word_t        rs1_data,
    input  rv_isa_pkg::word_t        rs2_data,
    input  pipe_pkg::fwd_t           fwd,
    output logic                     jump,
    output rv_isa_pkg::word_t        jump_target,
    output pipe_pkg::exec_payload_t  out,
    output logic                     out_valid
);

    rv_isa_pkg::inst_t inst;
    rv_isa_pkg::word_t raw;
    rv_isa_pkg::word_t imm_i;
    rv_isa_pkg::word_t imm_u;
    rv_isa_pkg::word_t op1;
    rv_isa_pkg::word_t op2;
    logic              squash; // slot behind a taken jump
    logic              is_nop;
    logic              live;

    function automatic pipe_pkg::alu_op_t alu_map(input rv_isa_pkg::funct3_t f3,
                                                  input logic alt);
        pipe_pkg::alu_op_t op;
        op = pipe_pkg::alu_add;
        case (f3)
            rv_isa_pkg::f3_add_sub: op = alt ? pipe_pkg::alu_sub : pipe_pkg::alu_add;
            rv_isa_pkg::f3_sll:     op = pipe_pkg::alu_sll;
            rv_isa_pkg::f3_slt:     op = pipe_pkg::alu_slt;
            rv_isa_pkg::f3_sltu:    op = pipe_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:     op = pipe_pkg::alu_xor;
            rv_isa_pkg::f3_srx:     op = alt ? pipe_pkg::alu_sra : pipe_pkg::alu_srl;
            rv_isa_pkg::f3_or:      op = pipe_pkg::alu_or;
            rv_isa_pkg::f3_and:     op = pipe_pkg::alu_and;
        endcase
        return op;
    endfunction

    assign inst  = in.inst;
    assign raw   = in.inst;
    assign rs1   = inst.rs1;
    assign rs2   = inst.rs2;
    assign imm_i = {{20{raw[31]}}, raw[31:20]};
    assign imm_u = {raw[31:12], 12'b0};

    // execute result wins over the register file
    assign op1 = (fwd.valid && fwd.rd == inst.rs1) ? fwd.data : rs1_data;
    assign op2 = (fwd.valid && fwd.rd == inst.rs2) ? fwd.data : rs2_data;

    assign is_nop    = (inst.opcode == rv_isa_pkg::opc_op_imm) && (raw[31:7] == '0);
    assign live      = in_valid && !squash && !is_nop;
    assign out_valid = live;

    branch_unit branch_i (
        .inst        (inst),
        .pc          (in.pc),
        .op1         (op1),
        .op2         (op2),
        .live        (live),
        .jump        (jump),
        .jump_target (jump_target)
    );

    always_comb begin
        out.op1    = op1;
        out.op2    = op2;
        out.rd     = inst.rd;
        out.alu_op = pipe_pkg::alu_add;
        out.wb     = 1'b1;
        case (inst.opcode)
            rv_isa_pkg::opc_op_imm: begin
                out.op2    = imm_i;
                out.alu_op = alu_map(inst.funct3,
                                     inst.funct3 == rv_isa_pkg::f3_srx && raw[30]);
            end
            rv_isa_pkg::opc_op: begin
                out.alu_op = alu_map(inst.funct3, raw[30]);
            end
            rv_isa_pkg::opc_lui: begin
                out.op1 = imm_u;
                out.op2 = '0;
            end
            rv_isa_pkg::opc_auipc: begin
                out.op1 = imm_u;
                out.op2 = in.pc;
            end
            rv_isa_pkg::opc_jal, rv_isa_pkg::opc_jalr: begin
                out.op1 = in.pc; // link = pc + 4
                out.op2 = rv_isa_pkg::inst_bytes;
            end
            default: out.wb = 1'b0; // branches, unsupported
        endcase
    end

    // frozen with fetch so a pending fetch keeps its pc
    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            squash <= 1'b0;
        end else if (!hold) begin
            squash <= jump;
        end
    end

endmodule

/* source/execute_stage.sv */
// alu and forwarding of its result back to decode
module execute_stage (
    input  pipe_pkg::exec_payload_t in,
    input  logic                    in_valid,
    output pipe_pkg::wb_payload_t   out,
    output pipe_pkg::fwd_t          fwd
);

    rv_isa_pkg::word_t result;
    logic [4:0]        shamt;

    assign shamt = in.op2[4:0];

    always_comb begin
        case (in.alu_op)
            pipe_pkg::alu_add:  result = in.op1 + in.op2;
            pipe_pkg::alu_sub:  result = in.op1 - in.op2;
            pipe_pkg::alu_sll:  result = in.op1 << shamt;
            pipe_pkg::alu_slt:  result = {31'b0, $signed(in.op1) < $signed(in.op2)};
            pipe_pkg::alu_sltu: result = {31'b0, in.op1 < in.op2};
            pipe_pkg::alu_xor:  result = in.op1 ^ in.op2;
            pipe_pkg::alu_srl:  result = in.op1 >> shamt;
            pipe_pkg::alu_sra:  result = $signed(in.op1) >>> shamt;
            pipe_pkg::alu_or:   result = in.op1 | in.op2;
            pipe_pkg::alu_and:  result = in.op1 & in.op2;
            default:            result = '0;
        endcase
    end

    assign out.rd   = in.rd;
    assign out.data = result;
    assign out.wb   = in.wb;

    // x0 never forwarded
    assign fwd.valid = in_valid && in.wb && (in.rd != '0);
    assign fwd.rd    = in.rd;
    assign fwd.data  = result;

endmodule

/* source/fetch_stage.sv */
// program counter, jump redirect and instruction memory request
module fetch_stage #(
    parameter rv_isa_pkg::word_t reset_pc = '0
) (
    input  logic                     ctrl_clk,
    input  logic                     ctrl_reset,
    input  logic                     jump,
    input  rv_isa_pkg::word_t        jump_target,
    output rv_isa_pkg::word_t        imem_addr,
    output logic                     imem_req,
    input  rv_isa_pkg::word_t        imem_data,
    input  logic                     imem_rdy,
    output pipe_pkg::fetch_payload_t out,
    output logic                     out_valid
);

    rv_isa_pkg::word_t pc;
    logic              active; // low through reset and the cycle after
    logic              accept;

    assign accept    = active && imem_rdy;
    assign imem_addr = pc;
    assign imem_req  = active;

    assign out.inst  = rv_isa_pkg::inst_t'(imem_data);
    assign out.pc    = pc;
    assign out_valid = accept;

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset) begin
            pc     <= reset_pc;
            active <= 1'b0;
        end else begin
            active <= 1'b1;
            if (accept) begin
                pc <= jump ? jump_target : pc + rv_isa_pkg::inst_bytes;
            end
        end
    end

endmodule

/* source/pipe_stage_reg.sv */
// stage register with valid bit, hold and bubble insertion
module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     ctrl_clk,
    input  logic     ctrl_reset,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge ctrl_clk) begin
        if (ctrl_reset || flush) begin
            out_valid <= 1'b0; // bubble
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves with a live entry
    always_ff @(posedge ctrl_clk) begin
        if (!hold && !flush && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

/* source/reg_file.sv */
// 32 x 32 register file, write port fed by the writeback entry
module reg_file (
    input  logic                  ctrl_clk,
    input  rv_isa_pkg::reg_addr_t rs1,
    input  rv_isa_pkg::reg_addr_t rs2,
    output rv_isa_pkg::word_t     rs1_data,
    output rv_isa_pkg::word_t     rs2_data,
    input  pipe_pkg::wb_payload_t wb,
    input  logic                  wb_valid
);

    rv_isa_pkg::word_t regs [1 << rv_isa_pkg::reg_addr_w];
    logic              writing;

    assign writing = wb_valid && wb.wb && (wb.rd != '0);

    // x0 hardwired, same-cycle write passes straight through
    assign rs1_data = (rs1 == '0) ? '0 :
                      (writing && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (writing && wb.rd == rs2) ? wb.data : regs[rs2];

    always_ff @(posedge ctrl_clk) begin
        if (writing) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

/* source/rv_core.sv */
// four-stage rv32i integer core, stages, stage registers and register file
module rv_core #(
    parameter rv_isa_pkg::word_t reset_pc = '0
) (
    input  logic                  ctrl_clk,
    input  logic                  ctrl_reset,
    output rv_isa_pkg::word_t     imem_addr,
    output logic                  imem_req,
    input  rv_isa_pkg::word_t     imem_data,
    input  logic                  imem_rdy,
    output pipe_pkg::wb_payload_t retire,
    output logic                  retire_valid
);

    logic                     stall;
    pipe_pkg::fetch_payload_t f_out;
    logic                     f_valid;
    pipe_pkg::fetch_payload_t fd_data;
    logic                     fd_valid;
    logic                     jump;
    rv_isa_pkg::word_t        jump_target;
    rv_isa_pkg::reg_addr_t    rs1;
    rv_isa_pkg::reg_addr_t    rs2;
    rv_isa_pkg::word_t        rs1_data;
    rv_isa_pkg::word_t        rs2_data;
    pipe_pkg::fwd_t           fwd;
    pipe_pkg::exec_payload_t  d_out;
    logic                     d_valid;
    pipe_pkg::exec_payload_t  dx_data;
    logic                     dx_valid;
    pipe_pkg::wb_payload_t    x_out;

    assign stall = ~imem_rdy; // only stall source

    fetch_stage #(
        .reset_pc (reset_pc)
    ) fetch_i (
        .ctrl_clk    (ctrl_clk),
        .ctrl_reset  (ctrl_reset),
        .jump        (jump),
        .jump_target (jump_target),
        .imem_addr   (imem_addr),
        .imem_req    (imem_req),
        .imem_data   (imem_data),
        .imem_rdy    (imem_rdy),
        .out         (f_out),
        .out_valid   (f_valid)
    );

    pipe_stage_reg #(
        .payload_t (pipe_pkg::fetch_payload_t)
    ) fd_reg_i (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .hold       (stall),
        .flush      (1'b0),
        .in_valid   (f_valid),
        .in_data    (f_out),
        .out_valid  (fd_valid),
        .out_data   (fd_data)
    );

    decode_stage decode_i (
        .ctrl_clk    (ctrl_clk),
        .ctrl_reset  (ctrl_reset),
        .hold        (stall),
        .in          (fd_data),
        .in_valid    (fd_valid),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .fwd         (fwd),
        .jump        (jump),
        .jump_target (jump_target),
        .out         (d_out),
        .out_valid   (d_valid)
    );

    // decode is frozen on a stall, so execute gets a bubble
    pipe_stage_reg #(
        .payload_t (pipe_pkg::exec_payload_t)
    ) dx_reg_i (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .hold       (1'b0),
        .flush      (stall),
        .in_valid   (d_valid),
        .in_data    (d_out),
        .out_valid  (dx_valid),
        .out_data   (dx_data)
    );

    execute_stage execute_i (
        .in       (dx_data),
        .in_valid (dx_valid),
        .out      (x_out),
        .fwd      (fwd)
    );

    pipe_stage_reg #(
        .payload_t (pipe_pkg::wb_payload_t)
    ) xw_reg_i (
        .ctrl_clk   (ctrl_clk),
        .ctrl_reset (ctrl_reset),
        .hold       (1'b0),
        .flush      (1'b0),
        .in_valid   (dx_valid),
        .in_data    (x_out),
        .out_valid  (retire_valid),
        .out_data   (retire)
    );

    reg_file reg_file_i (
        .ctrl_clk (ctrl_clk),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (retire),
        .wb_valid (retire_valid)
    );

endmodule

/* tb.f */
common/rv_isa_pkg.sv
common/pipe_pkg.sv
source/pipe_stage_reg.sv
source/reg_file.sv
source/fetch_stage.sv
decode/branch_unit.sv
decode/decode_stage.sv
source/execute_stage.sv
source/rv_core.sv
bench/rv_core_assert.sv
bench/tb_rv_core.sv
